/* permuteConsts.svh */
`ifndef PERMUTE_CONSTS_SVH
`define PERMUTE_CONSTS_SVH

// truth table of a 7-variable function
`define PERM_FUNC_BITS 128

// permutations of the four upper variables
`define PERM_COUNT 24

`define PERM_FIFO_DEPTH 4 // mask buffer entries

`define PERM_COUNT_BITS 16 // width of one frame total

`endif

/* boolFuncPkg.sv */
`include "permuteConsts.svh"

package boolFuncPkg;

    localparam int PART_COUNT = 16; // parts addressed by the four upper vars
    localparam int PART_BITS  = `PERM_FUNC_BITS / PART_COUNT; // low three vars stay in place

    typedef logic [`PERM_FUNC_BITS-1:0] funcT; // full truth table
    typedef logic [PART_BITS-1:0]       partT; // one block of the three fixed vars

    // part indices, bit 0 is var a, bit 3 is var d
    localparam logic [3:0] ONE_VAR_PARTS [4] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000}; // a b c d
    // pairs ab ac ad cd bd bc, entry k+3 is the complement of entry k
    localparam logic [3:0] TWO_VAR_PARTS [6] = '{4'b0011, 4'b0101, 4'b1001,
                                                 4'b1100, 4'b1010, 4'b0110};
    // indexed by the missing var, so bcd acd abd abc
    localparam logic [3:0] THREE_VAR_PARTS [4] = '{4'b1110, 4'b1101, 4'b1011, 4'b0111};

    localparam logic [3:0] NO_VAR_PART  = 4'b0000; // fixed by every permutation
    localparam logic [3:0] ALL_VAR_PART = 4'b1111; // fixed by every permutation

endpackage

/* permutePkg.sv */
`include "permuteConsts.svh"

package permutePkg;

    // one bit per permutation whose check passed, a-group in the top six bits
    typedef logic [`PERM_COUNT-1:0] permMaskT;

    typedef struct packed {
        logic     last; // closes a frame
        permMaskT mask;
    } permBeatT; // 25 bits

    typedef logic [`PERM_COUNT_BITS-1:0] countT; // frame total

endpackage

/* permuteIntermediaries24.sv */
`timescale 1ns/1ns

module permuteIntermediaries24 (
    input  boolFuncPkg::funcT top,
    input  boolFuncPkg::funcT bot,
    output logic              sharedAll,           // parts 0000 and 1111 already below top
    output logic [15:0]       oneThreeVarOverlaps, // [location*4+var]
    output logic [17:0]       twoTwoVarOverlaps    // [pairShape*6+pair]
);
    import boolFuncPkg::*;

    partT topParts [PART_COUNT];
    partT botParts [PART_COUNT];

    // true when every set bit of b is also set in t
    function automatic logic covers(input partT t, input partT b);
        covers = &(t | ~b);
    endfunction

    for (genvar p = 0; p < PART_COUNT; p++) begin : gSplit
        assign topParts[p] = top[p*PART_BITS +: PART_BITS];
        assign botParts[p] = bot[p*PART_BITS +: PART_BITS];
    end

    assign sharedAll = covers(topParts[NO_VAR_PART], botParts[NO_VAR_PART])
                     & covers(topParts[ALL_VAR_PART], botParts[ALL_VAR_PART]);

    // var j sent to location i moves part {j} to {i} and its complement along with it
    for (genvar i = 0; i < 4; i++) begin : gOneLoc
        for (genvar j = 0; j < 4; j++) begin : gOneVar
            assign oneThreeVarOverlaps[i*4+j] =
                covers(topParts[ONE_VAR_PARTS[i]], botParts[ONE_VAR_PARTS[j]])
              & covers(topParts[THREE_VAR_PARTS[i]], botParts[THREE_VAR_PARTS[j]]);
        end
    end

    // shapes XX__, X_X_, X__X, each paired with its complement
    for (genvar i = 0; i < 3; i++) begin : gTwoShape
        for (genvar j = 0; j < 6; j++) begin : gTwoPair
            assign twoTwoVarOverlaps[i*6+j] =
                covers(topParts[TWO_VAR_PARTS[i]], botParts[TWO_VAR_PARTS[j]])
              & covers(topParts[TWO_VAR_PARTS[i+3]], botParts[TWO_VAR_PARTS[(j+3)%6]]);
        end
    end

endmodule

/* permuteCheck24.sv */
`timescale 1ns/1ns

module permuteCheck24 (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 botValid,
    output logic                 botReady,
    input  boolFuncPkg::funcT    top,
    input  boolFuncPkg::funcT    bot,
    input  logic                 botIsValid, // low means the beat passes no permutation
    input  logic                 botLast,
    output logic                 checkValid,
    input  logic                 checkReady,
    output permutePkg::permBeatT checkBeat
);
    import permutePkg::*;

    // per removed var: the other three vars, removed one swapped to slot 0
    localparam int FLAVOR [4][3] = '{'{1, 2, 3}, '{0, 2, 3}, '{1, 0, 3}, '{1, 2, 0}};
    // pair {removed, flavor} as index into ab ac ad cd bd bc
    localparam int PAIR   [4][3] = '{'{0, 1, 2}, '{0, 5, 4}, '{5, 1, 3}, '{4, 3, 2}};
    // abc acb bac bca cab cba over the three flavors
    localparam int ORDER  [6][3] = '{'{0, 1, 2}, '{0, 2, 1}, '{1, 0, 2},
                                     '{1, 2, 0}, '{2, 0, 1}, '{2, 1, 0}};

    logic        interShared;
    logic [15:0] interOneThree;
    logic [17:0] interTwoTwo;
    logic        s1Valid;
    logic        s1Shared;   // stage 1 payload
    logic [15:0] s1OneThree;
    logic [17:0] s1TwoTwo;
    logic        s1IsValid;
    logic        s1Last;
    logic        s1Ready;
    logic        s2Valid;
    logic        s2Ready;
    permBeatT    s2Beat;
    permMaskT    nextMask;   // combined result of stage 1 contents

    permuteIntermediaries24 uInter (
        .top                 (top),
        .bot                 (bot),
        .sharedAll           (interShared),
        .oneThreeVarOverlaps (interOneThree),
        .twoTwoVarOverlaps   (interTwoTwo)
    );

    assign s2Ready  = !s2Valid || checkReady; // empty or moving
    assign s1Ready  = !s1Valid || s2Ready;
    assign botReady = s1Ready;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
        end else begin
            if (s1Ready) s1Valid <= botValid;
            if (s2Ready) s2Valid <= s1Valid;
        end
    end

    always_ff @(posedge clk) begin
        if (botValid && s1Ready) begin // stage 1 captures intermediaries
            s1Shared   <= interShared;
            s1OneThree <= interOneThree;
            s1TwoTwo   <= interTwoTwo;
            s1IsValid  <= botIsValid;
            s1Last     <= botLast;
        end
        if (s1Valid && s2Ready) begin
            s2Beat.mask <= nextMask;
            s2Beat.last <= s1Last;
        end
    end

    // group g sends var g to location 0, six orders remain for the rest
    for (genvar g = 0; g < 4; g++) begin : gGroup
        logic       groupShared;
        logic [8:0] oneTwo; // [(location-1)*3+flavor]
        assign groupShared = s1IsValid & s1Shared & s1OneThree[g]; // location 0 is index 0*4+g
        for (genvar i = 0; i < 3; i++) begin : gLoc
            for (genvar k = 0; k < 3; k++) begin : gFlavor
                assign oneTwo[i*3+k] = s1OneThree[4*(i+1)+FLAVOR[g][k]]
                                     & s1TwoTwo[6*i+PAIR[g][k]];
            end
        end
        for (genvar p = 0; p < 6; p++) begin : gPerm
            assign nextMask[(3-g)*6+(5-p)] = groupShared
                                           & oneTwo[ORDER[p][0]]
                                           & oneTwo[3+ORDER[p][1]]
                                           & oneTwo[6+ORDER[p][2]];
        end
    end

    assign checkValid = s2Valid;
    assign checkBeat  = s2Beat;

    // a stalled beat holds until the FIFO takes it
    stallHold: assert property (@(posedge clk) disable iff (!arstN)
        checkValid && !checkReady |=> checkValid && $stable(checkBeat));

endmodule

/* maskFifo.sv */
`timescale 1ns/1ns
`include "permuteConsts.svh"

module maskFifo (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 pushValid,
    output logic                 pushReady, // not full
    input  permutePkg::permBeatT pushBeat,
    output logic                 popValid,  // not empty
    input  logic                 popReady,
    output permutePkg::permBeatT popBeat
);
    import permutePkg::*;

    localparam int DEPTH    = `PERM_FIFO_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    permBeatT            mem [DEPTH];
    logic [PTR_BITS-1:0] wrPtr;
    logic [PTR_BITS-1:0] rdPtr;
    logic [CNT_BITS-1:0] occupancy;
    logic                doPush;
    logic                doPop;

    assign pushReady = occupancy != CNT_BITS'(DEPTH);
    assign popValid  = occupancy != '0;
    assign doPush    = pushValid && pushReady;
    assign doPop     = popValid && popReady;
    assign popBeat   = mem[rdPtr]; // head entry

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            occupancy <= '0;
        end else begin
            if (doPush) wrPtr <= (wrPtr == PTR_BITS'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            if (doPop)  rdPtr <= (rdPtr == PTR_BITS'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            if (doPush && !doPop) occupancy <= occupancy + 1'b1;
            else if (doPop && !doPush) occupancy <= occupancy - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) mem[wrPtr] <= pushBeat;
    end

    occupancyBound: assert property (@(posedge clk) disable iff (!arstN)
        occupancy <= CNT_BITS'(DEPTH));

    // a pop with equal pointers is only legal when the buffer is full
    popNotEmpty: assert property (@(posedge clk) disable iff (!arstN)
        doPop |-> wrPtr != rdPtr || occupancy == CNT_BITS'(DEPTH));

endmodule

/* permutationCounter.sv */
`timescale 1ns/1ns

module permutationCounter (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 maskValid,
    output logic                 maskReady,
    input  permutePkg::permBeatT maskBeat,
    output logic                 countValid,
    input  logic                 countReady,
    output permutePkg::countT    count
);
    import permutePkg::*;

    localparam int POP_BITS = $clog2($bits(permMaskT) + 1); // holds 0..24

    logic [POP_BITS-1:0] popCount;
    countT               accum;    // running total of the open frame
    countT               frameSum; // accum plus the beat being popped
    logic                doPop;

    assign popCount  = POP_BITS'($countones(maskBeat.mask));
    assign frameSum  = accum + countT'(popCount);
    assign maskReady = !countValid; // hold off while a total waits
    assign doPop     = maskValid && maskReady;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            accum      <= '0;
            countValid <= 1'b0;
        end else begin
            if (doPop) accum <= maskBeat.last ? '0 : frameSum; // restart on frame end
            if (doPop && maskBeat.last) countValid <= 1'b1;
            else if (countValid && countReady) countValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (doPop && maskBeat.last) count <= frameSum; // latch the frame total
    end

    // a frame end raises the total and blocks the next pop
    lastRaisesTotal: assert property (@(posedge clk) disable iff (!arstN)
        doPop && maskBeat.last |=> countValid && !doPop);

endmodule

/* permuteCountTop.sv */
`timescale 1ns/1ns

module permuteCountTop (
    input  logic              clk,
    input  logic              arstN,
    input  logic              botValid,
    output logic              botReady,
    input  boolFuncPkg::funcT top,
    input  boolFuncPkg::funcT bot,
    input  logic              botIsValid,
    input  logic              botLast,
    output logic              countValid, // one pulse-until-taken per frame
    input  logic              countReady,
    output permutePkg::countT count
);
    import permutePkg::*;

    logic     checkValid;
    logic     checkReady;
    permBeatT checkBeat;
    logic     maskValid;
    logic     maskReady;
    permBeatT maskBeat;

    permuteCheck24 uCheck (
        .clk        (clk),
        .arstN      (arstN),
        .botValid   (botValid),
        .botReady   (botReady),
        .top        (top),
        .bot        (bot),
        .botIsValid (botIsValid),
        .botLast    (botLast),
        .checkValid (checkValid),
        .checkReady (checkReady),
        .checkBeat  (checkBeat)
    );

    maskFifo uFifo (
        .clk       (clk),
        .arstN     (arstN),
        .pushValid (checkValid),
        .pushReady (checkReady), // full FIFO stalls the checker
        .pushBeat  (checkBeat),
        .popValid  (maskValid),
        .popReady  (maskReady),
        .popBeat   (maskBeat)
    );

    permutationCounter uCounter (
        .clk        (clk),
        .arstN      (arstN),
        .maskValid  (maskValid),
        .maskReady  (maskReady),
        .maskBeat   (maskBeat),
        .countValid (countValid),
        .countReady (countReady),
        .count      (count)
    );

endmodule

/* permuteCountTb.sv */
`timescale 1ns/1ns

module permuteCountTb;
    import boolFuncPkg::*;
    import permutePkg::*;

    localparam int WAIT_LIMIT  = 200;  // cycles for one input handshake
    localparam int DRAIN_LIMIT = 4000; // cycles for all outstanding totals

    logic clk;
    logic arstN;
    logic botValid;
    logic botReady;
    funcT top;
    funcT bot;
    logic botIsValid;
    logic botLast;
    logic countValid;
    logic countReady;
    countT count;

    countT       expQ [$];   // expected totals with the oldest frame first
    int unsigned frameExp;   // running total of the frame being sent
    int unsigned errors;
    int unsigned timeouts;
    int unsigned framesSent;
    int unsigned framesChecked;
    logic [31:0] stimSeed;
    logic [31:0] readySeed;
    logic        stallMode;  // random back-pressure on countReady
    logic        gapMode;    // random idle cycles between beats

    permuteCountTop u_dut (
        .clk        (clk),
        .arstN      (arstN),
        .botValid   (botValid),
        .botReady   (botReady),
        .top        (top),
        .bot        (bot),
        .botIsValid (botIsValid),
        .botLast    (botLast),
        .countValid (countValid),
        .countReady (countReady),
        .count      (count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        lcgNext = s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] randWord();
        stimSeed = lcgNext(stimSeed);
        return stimSeed;
    endfunction

    function automatic funcT randFunc();
        return {randWord(), randWord(), randWord(), randWord()};
    endfunction

    // brute force over the 24 orders of the four upper index bits
    function automatic int unsigned refPerms(input funcT t, input funcT b);
        int unsigned hits;
        int          perm [4];
        logic [3:0]  seen;
        logic        ok;
        logic [6:0]  idx;
        logic [3:0]  dst;
        hits = 0;
        for (int code = 0; code < 256; code++) begin
            seen = '0;
            for (int j = 0; j < 4; j++) begin
                perm[j] = (code >> (2 * j)) & 3; // two bits per target slot
                seen[perm[j]] = 1'b1;
            end
            if (seen == 4'b1111) begin // a true permutation
                ok = 1'b1;
                for (int n = 0; n < 128; n++) begin
                    idx = 7'(n);
                    dst = '0;
                    for (int j = 0; j < 4; j++) dst[perm[j]] = idx[3+j];
                    if (b[n] && !t[{dst, idx[2:0]}]) ok = 1'b0;
                end
                if (ok) hits++;
            end
        end
        return hits;
    endfunction

    // one beat through the input handshake and the frame total queued on last
    task automatic sendPair(input funcT t, input funcT b, input logic isValid,
                            input logic last, input int unsigned expBeat);
        int waitCycles;
        int gapLen;
        if (timeouts != 0) return;
        gapLen = gapMode ? int'((randWord() >> 16) % 3) : 0;
        repeat (gapLen) begin
            botValid <= 1'b0;
            @(posedge clk);
        end
        botValid   <= 1'b1;
        top        <= t;
        bot        <= b;
        botIsValid <= isValid;
        botLast    <= last;
        waitCycles = 0;
        do begin
            @(posedge clk);
            waitCycles++;
        end while (!botReady && waitCycles < WAIT_LIMIT);
        if (!botReady) begin
            $display("timeout: botReady stayed low for %0d cycles", waitCycles);
            timeouts++;
        end
        frameExp += expBeat;
        if (last) begin
            expQ.push_back(countT'(frameExp));
            frameExp = 0;
            framesSent++;
        end
    endtask

    task automatic sendRandomFrame();
        int          beats;
        int unsigned kind;
        funcT        t;
        funcT        b;
        logic        isValid;
        beats = int'((randWord() >> 16) % 6) + 1;
        for (int i = 0; i < beats; i++) begin
            kind = (randWord() >> 16) % 3;
            t = randFunc();
            if (kind == 0) begin
                b = t & randFunc(); // bot below top so the identity always passes
            end else if (kind == 1) begin
                t = t | randFunc();
                b = randFunc() & randFunc() & randFunc();
            end else begin
                b = randFunc() & randFunc();
            end
            isValid = (randWord() >> 29) != 0;
            sendPair(t, b, isValid, i == beats - 1, isValid ? refPerms(t, b) : 0);
        end
    endtask

    // loop until every queued total has been taken
    task automatic waitDrain();
        int cycles;
        botValid <= 1'b0;
        cycles = 0;
        while (expQ.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (expQ.size() != 0) begin
            $display("timeout: %0d frame totals never arrived", expQ.size());
            timeouts++;
        end
    endtask

    always @(posedge clk) begin
        readySeed = lcgNext(readySeed);
        countReady <= stallMode ? (readySeed[31:30] == 2'b00) : 1'b1; // mostly low when stalling
    end

    always @(posedge clk) begin
        if (arstN && countValid && countReady) begin
            if (expQ.size() == 0) begin
                $display("total 0x%h arrived with no frame outstanding", count);
                errors++;
            end else begin
                countMatch: assert (count == expQ[0]) else begin
                    $display("FAIL count got 0x%h expected 0x%h", count, expQ[0]);
                    errors++;
                end
                void'(expQ.pop_front());
                framesChecked++;
            end
        end
    end

    countHeld: assert property (@(posedge clk) disable iff (!arstN)
        countValid && !countReady |=> countValid && $stable(count)) else begin
        $display("count or countValid changed while the total was stalled");
        errors++;
    end

    initial begin
        funcT matchFunc; // top and bot of the matching invalid beats
        arstN = 1'b0;
        botValid = 1'b0;
        top = '0;
        bot = '0;
        botIsValid = 1'b0;
        botLast = 1'b0;
        countReady = 1'b1;
        stimSeed = 32'hd308_6b34;
        readySeed = lcgNext(32'hd308_6b34); // own stream for back-pressure
        stallMode = 1'b0;
        gapMode = 1'b0;
        frameExp = 0;
        errors = 0;
        timeouts = 0;
        framesSent = 0;
        framesChecked = 0;
        repeat (2) @(posedge clk);
        arstN <= 1'b1;
        @(posedge clk);
        resetIdle: assert (!countValid && botReady) else begin
            $display("FAIL after reset countValid=0x%h botReady=0x%h", countValid, botReady);
            errors++;
        end

        // bot empty or top full passes all 24
        sendPair(randFunc(), '0, 1'b1, 1'b1, 24);
        for (int i = 0; i < 5; i++) begin
            if (i < 3) sendPair(randFunc(), '0, 1'b1, 1'b0, 24);
            else sendPair('1, randFunc(), 1'b1, i == 4, 24);
        end
        waitDrain();

        // invalid beats add nothing
        matchFunc = randFunc();
        sendPair(matchFunc, matchFunc, 1'b0, 1'b1, 0);
        sendPair(matchFunc, matchFunc, 1'b0, 1'b0, 0);
        sendPair(randFunc(), '0, 1'b0, 1'b0, 0);
        sendPair('1, randFunc(), 1'b1, 1'b1, 24);
        waitDrain();

        for (int f = 0; f < 20; f++) sendRandomFrame();
        waitDrain();

        stallMode <= 1'b1; // FIFO fills and the checker stalls
        gapMode   <= 1'b1;
        for (int f = 0; f < 20; f++) sendRandomFrame();
        waitDrain();
        stallMode <= 1'b0;
        repeat (4) @(posedge clk);

        framesDone: assert (framesChecked == framesSent) else begin
            $display("only %0d of %0d frame totals were checked", framesChecked, framesSent);
            errors++;
        end
        $display("errors=%0d timeouts=%0d frames=%0d", errors, timeouts, framesChecked);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+.
boolFuncPkg.sv
permutePkg.sv
permuteIntermediaries24.sv
permuteCheck24.sv
maskFifo.sv
permutationCounter.sv
permuteCountTop.sv
permuteCountTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= permuteCountTb
OBJ_DIR   ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
